// File: filelist.f
+incdir+include
verilog/renamePkg.sv
verilog/regFile.sv
verilog/reorderBuffer.sv
verilog/aluUnit.sv
verilog/renameCore.sv
dv/renameCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f filelist.f --top-module renameCoreTb -Mdir obj_dir

simOut=$(./obj_dir/VrenameCoreTb 2>&1) || true
echo "$simOut"

if grep -qx "TEST RESULT: PASS" <<< "$simOut"; then
    exit 0
fi
exit 1

// File: dv/renameCoreTb.sv
`timescale 1ns/1ps
`include "rename_params.svh"

module renameCoreTb
    import renamePkg::*;
();

    localparam int NUM_INSTR  = 3000;
    localparam int WAIT_LIMIT = 200;
    localparam int FLUSH_PCT  = 2;
    localparam int MAX_CYCLES = NUM_INSTR * 40;

    typedef struct packed {
        opT      op;
        regNameT rd;
        regNameT rs1;
        regNameT rs2;
        dataT    imm;
        dataT    pc;
    } instrT;

    logic    clk;
    logic    rst;
    logic    flush;
    logic    inValid;
    logic    inReady;
    opT      inOp;
    regNameT inRd;
    regNameT inRs1;
    regNameT inRs2;
    dataT    inImm;
    dataT    inPc;
    logic    commitEn;
    regNameT commitRd;
    dataT    commitData;
    dataT    commitPc;

    // Architectural model state is updated in commit order
    dataT  archReg [`REG_NUM];
    instrT pendQ [$];
    instrT curInstr;
    dataT  nextPc;
    logic  lastAccepted;
    logic  draining;
    int    accepted;
    int    stallCycles;
    int    gapPct;
    int    cycleCount;
    int    drainCycles;

    renameCore DUT (
        .clk,
        .rst,
        .flush,
        .inValid,
        .inReady,
        .inOp,
        .inRd,
        .inRs1,
        .inRs2,
        .inImm,
        .inPc,
        .commitEn,
        .commitRd,
        .commitData,
        .commitPc
    );

    always #5 clk = ~clk;

    task automatic stopWithFailure(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    // ****************************************
    // Stimulus
    // ****************************************

    // Mostly x0 to x7 so that dependencies are frequent
    function automatic regNameT pickReg();
        if ($urandom_range(9, 0) < 8) begin
            return regNameT'($urandom_range(7, 0));
        end
        return regNameT'($urandom_range(31, 0));
    endfunction

    function automatic instrT newInstr(input dataT pc);
        instrT      ins;
        logic [11:0] imm12;
        imm12   = 12'($urandom());
        ins.op  = opT'($urandom_range(7, 0));
        ins.rd  = pickReg();
        ins.rs1 = pickReg();
        ins.rs2 = pickReg();
        ins.pc  = pc;
        if (ins.op == OP_ADDI) begin
            ins.imm = {{20{imm12[11]}}, imm12};
        end else if (ins.op == OP_LUI) begin
            ins.imm = {20'($urandom()), 12'h000};
        end else begin
            // Register forms must ignore whatever sits in the immediate
            ins.imm = $urandom();
        end
        return ins;
    endfunction

    task automatic driveInputs();
        flush = !draining && ($urandom_range(99, 0) < FLUSH_PCT);
        if (draining) begin
            inValid = 1'b0;
        end else if (inValid && !lastAccepted) begin
            // Fields stay put until the transfer happens
        end else if ($urandom_range(99, 0) < gapPct) begin
            inValid = 1'b0;
        end else begin
            curInstr = newInstr(nextPc);
            nextPc   = nextPc + 32'd4;
            inValid  = 1'b1;
            inOp     = curInstr.op;
            inRd     = curInstr.rd;
            inRs1    = curInstr.rs1;
            inRs2    = curInstr.rs2;
            inImm    = curInstr.imm;
            inPc     = curInstr.pc;
        end
    endtask

    // ****************************************
    // Reference model and checks
    // ****************************************

    function automatic dataT archResult(input instrT ins);
        dataT a;
        dataT b;
        a = archReg[ins.rs1];
        b = archReg[ins.rs2];
        case (ins.op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_ADDI: return a + ins.imm;
            OP_LUI:  return ins.imm;
            default: return '0;
        endcase
    endfunction

    task automatic checkCommit();
        instrT ins;
        dataT  expData;
        assert (pendQ.size() > 0)
        else stopWithFailure("commit seen with no accepted instruction outstanding");
        ins     = pendQ.pop_front();
        expData = archResult(ins);
        assert (commitPc == ins.pc)
        else stopWithFailure($sformatf("mismatch commitPc: got 0x%08h expected 0x%08h",
                                       commitPc, ins.pc));
        assert (commitRd == ins.rd)
        else stopWithFailure($sformatf("mismatch commitRd: got 0x%02h expected 0x%02h",
                                       commitRd, ins.rd));
        assert (commitData == expData)
        else stopWithFailure($sformatf("mismatch commitData: got 0x%08h expected 0x%08h",
                                       commitData, expData));
        // x0 stays zero in the model as well
        if (ins.rd != '0) begin
            archReg[ins.rd] = expData;
        end
    endtask

    task automatic sampleOutputs();
        if (rst || flush) begin
            assert (!inReady && !commitEn)
            else stopWithFailure("inReady or commitEn was high during reset or flush");
        end
        // Every outstanding instruction holds one buffer entry
        if (!rst && !flush && pendQ.size() >= `ROB_DEPTH) begin
            assert (!inReady)
            else stopWithFailure($sformatf("mismatch inReady: got 0x%0h expected 0x0",
                                           inReady));
        end
        if (flush) begin
            pendQ.delete();
        end
        if (commitEn) begin
            checkCommit();
        end
        lastAccepted = inValid && inReady;
        if (lastAccepted) begin
            pendQ.push_back(curInstr);
            accepted++;
        end
        if (commitEn || lastAccepted || (pendQ.size() == 0 && !inValid)) begin
            stallCycles = 0;
        end else begin
            stallCycles++;
        end
        assert (stallCycles < WAIT_LIMIT)
        else stopWithFailure("no commit and no transfer for 200 cycles while work was waiting");
    endtask

    task automatic runCycle();
        @(posedge clk);
        #1;
        driveInputs();
        @(negedge clk);
        sampleOutputs();
        cycleCount++;
    endtask

    // ****************************************
    // Main sequence
    // ****************************************

    initial begin
        void'($urandom(32'hc3f608a5));
        clk          = 1'b0;
        rst          = 1'b1;
        flush        = 1'b0;
        inValid      = 1'b0;
        inOp         = OP_ADD;
        inRd         = '0;
        inRs1        = '0;
        inRs2        = '0;
        inImm        = '0;
        inPc         = '0;
        curInstr     = '0;
        nextPc       = 32'h0000_1000;
        lastAccepted = 1'b0;
        draining     = 1'b0;
        accepted     = 0;
        stallCycles  = 0;
        gapPct       = 25;
        cycleCount   = 0;
        drainCycles  = 0;
        for (int i = 0; i < `REG_NUM; i++) begin
            archReg[i] = '0;
        end

        repeat (8) begin
            @(posedge clk);
            #1;
            sampleOutputs();
        end
        rst = 1'b0;

        // Blocks with gaps alternate with gapless blocks that fill the buffer
        while (accepted < NUM_INSTR) begin
            gapPct = ((accepted / 250) % 2 == 0) ? 25 : 0;
            runCycle();
            assert (cycleCount < MAX_CYCLES)
            else stopWithFailure("instruction stream did not finish within the cycle limit");
        end

        draining = 1'b1;
        while (pendQ.size() != 0) begin
            runCycle();
            drainCycles++;
            assert (drainCycles < WAIT_LIMIT)
            else stopWithFailure("pipeline did not drain within 200 cycles");
        end

        // Any late commit here has no model entry and fails the check
        repeat (10) begin
            runCycle();
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: verilog/renameCore.sv
`timescale 1ns/1ps
`include "rename_params.svh"

module renameCore
    import renamePkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    flush,

    input  logic    inValid,
    output logic    inReady,
    input  opT      inOp,
    input  regNameT inRd,
    input  regNameT inRs1,
    input  regNameT inRs2,
    input  dataT    inImm,
    input  dataT    inPc,

    output logic    commitEn,
    output regNameT commitRd,
    output dataT    commitData,
    output dataT    commitPc
);

    dataT    rs1Data;
    dataT    rs2Data;
    tagT     rs1Tag;
    tagT     rs2Tag;

    logic    renameEn;
    regNameT renameRd;
    tagT     renameTag;

    logic    issueEn;
    opT      issueOp;
    dataT    issueA;
    dataT    issueB;
    tagT     issueTag;

    logic    resultEn;
    tagT     resultTag;
    dataT    resultData;

    tagT     commitTag;

    // ****************************************
    // Architectural state
    // ****************************************

    regFile regs (
        .clk, .rst, .flush,
        .rs1(inRs1), .rs2(inRs2),
        .rs1Data, .rs2Data, .rs1Tag, .rs2Tag,
        .renameEn, .renameRd, .renameTag,
        .commitEn, .commitRd, .commitTag, .commitData
    );

    // ****************************************
    // Reorder buffer and execution
    // ****************************************

    reorderBuffer rob (
        .clk, .rst, .flush,
        .inValid, .inReady, .inOp, .inRd, .inImm, .inPc,
        .rs1Data, .rs1Tag, .rs2Data, .rs2Tag,
        .renameEn, .renameRd, .renameTag,
        .issueEn, .issueOp, .issueA, .issueB, .issueTag,
        .resultEn, .resultTag, .resultData,
        .commitEn, .commitRd, .commitTag, .commitData, .commitPc
    );

    aluUnit alu (
        .clk, .rst,
        .issueEn, .issueOp, .issueA, .issueB, .issueTag,
        .resultEn, .resultTag, .resultData
    );

endmodule

// File: verilog/aluUnit.sv
`timescale 1ns/1ps
`include "rename_params.svh"

module aluUnit
    import renamePkg::*;
(
    input  logic clk,
    input  logic rst,

    input  logic issueEn,
    input  opT   issueOp,
    input  dataT issueA,
    input  dataT issueB,
    input  tagT  issueTag,

    output logic resultEn,
    output tagT  resultTag,
    output dataT resultData
);

    dataT aluOut;
    logic lessThan;

    assign lessThan = $signed(issueA) < $signed(issueB);

    always_comb begin
        case (issueOp)
            // Immediate forms share the adder
            OP_ADD, OP_ADDI, OP_LUI: aluOut = issueA + issueB;
            OP_SUB:                  aluOut = issueA - issueB;
            OP_AND:                  aluOut = issueA & issueB;
            OP_OR:                   aluOut = issueA | issueB;
            OP_XOR:                  aluOut = issueA ^ issueB;
            OP_SLT:                  aluOut = {{(`DATA_W-1){1'b0}}, lessThan};
            default:                 aluOut = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resultEn <= 1'b0;
        end else begin
            resultEn <= issueEn;
        end
    end

    always_ff @(posedge clk) begin
        resultTag  <= issueTag;
        resultData <= aluOut;
    end

endmodule

// File: verilog/reorderBuffer.sv
`timescale 1ns/1ps
`include "rename_params.svh"

module reorderBuffer
    import renamePkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    flush,

    // Upstream instruction entry
    input  logic    inValid,
    output logic    inReady,
    input  opT      inOp,
    input  regNameT inRd,
    input  dataT    inImm,
    input  dataT    inPc,

    // Source operands from the register file
    input  dataT    rs1Data,
    input  tagT     rs1Tag,
    input  dataT    rs2Data,
    input  tagT     rs2Tag,

    output logic    renameEn,
    output regNameT renameRd,
    output tagT     renameTag,

    // ALU issue and result broadcast
    output logic    issueEn,
    output opT      issueOp,
    output dataT    issueA,
    output dataT    issueB,
    output tagT     issueTag,
    input  logic    resultEn,
    input  tagT     resultTag,
    input  dataT    resultData,

    output logic    commitEn,
    output regNameT commitRd,
    output tagT     commitTag,
    output dataT    commitData,
    output dataT    commitPc
);

    // Entry i carries tag i+1
    logic [`ROB_DEPTH-1:0] entValid;
    logic [`ROB_DEPTH-1:0] entIssued;
    logic [`ROB_DEPTH-1:0] entDone;
    logic [`ROB_DEPTH-1:0] entARdy;
    logic [`ROB_DEPTH-1:0] entBRdy;

    opT      entOp     [`ROB_DEPTH];
    regNameT entRd     [`ROB_DEPTH];
    dataT    entPc     [`ROB_DEPTH];
    dataT    entResult [`ROB_DEPTH];
    dataT    entAVal   [`ROB_DEPTH];
    dataT    entBVal   [`ROB_DEPTH];
    tagT     entATag   [`ROB_DEPTH];
    tagT     entBTag   [`ROB_DEPTH];

    logic [`TAG_W-1:0] headPtr;
    logic [`TAG_W-1:0] tailPtr;
    logic [`TAG_W-1:0] count;
    logic [`TAG_W-1:0] issueIdx;
    logic              issueFound;
    logic              accept;
    tagT               resIdx;

    logic newARdy;
    logic newBRdy;
    dataT newAVal;
    dataT newBVal;
    tagT  newATag;
    tagT  newBTag;

    function automatic logic [`TAG_W-1:0] nextPtr(input logic [`TAG_W-1:0] p);
        return (int'(p) == `ROB_DEPTH - 1) ? '0 : p + 1'b1;
    endfunction

    // A pending source takes a finished entry first and then this cycle's broadcast
    function automatic void resolveSrc(
        input  tagT  srcTag,
        input  dataT srcData,
        output logic srcRdy,
        output dataT srcVal
    );
        tagT srcIdx;
        srcIdx = srcTag - tagT'(1);
        srcRdy = 1'b1;
        srcVal = srcData;
        if (srcTag != '0) begin
            if (entDone[srcIdx]) begin
                srcVal = entResult[srcIdx];
            end else if (resultEn && resultTag == srcTag) begin
                srcVal = resultData;
            end else begin
                srcRdy = 1'b0;
            end
        end
    endfunction

    // ****************************************
    // Dispatch and rename
    // ****************************************

    assign inReady   = !rst && !flush && (int'(count) < `ROB_DEPTH);
    assign accept    = inValid && inReady;
    assign renameEn  = accept && (inRd != '0);
    assign renameRd  = inRd;
    assign renameTag = tailPtr + 1'b1;

    always_comb begin
        resolveSrc(rs1Tag, rs1Data, newARdy, newAVal);
        resolveSrc(rs2Tag, rs2Data, newBRdy, newBVal);
        newATag = rs1Tag;
        newBTag = rs2Tag;
        if (inOp == OP_LUI) begin
            newARdy = 1'b1;
            newAVal = '0;
            newATag = '0;
        end
        if (inOp == OP_ADDI || inOp == OP_LUI) begin
            newBRdy = 1'b1;
            newBVal = inImm;
            newBTag = '0;
        end
    end

    // ****************************************
    // Oldest-ready issue
    // ****************************************

    always_comb begin : issueSelect
        int idx;
        issueFound = 1'b0;
        issueIdx   = '0;
        for (int k = 0; k < `ROB_DEPTH; k++) begin
            idx = int'(headPtr) + k;
            if (idx >= `ROB_DEPTH) begin
                idx = idx - `ROB_DEPTH;
            end
            if (!issueFound && entValid[idx] && !entIssued[idx] &&
                entARdy[idx] && entBRdy[idx]) begin
                issueFound = 1'b1;
                issueIdx   = idx[`TAG_W-1:0];
            end
        end
    end

    // Nothing leaves during flush, so no stale tag comes back afterwards
    assign issueEn  = issueFound && !flush;
    assign issueOp  = entOp[issueIdx];
    assign issueA   = entAVal[issueIdx];
    assign issueB   = entBVal[issueIdx];
    assign issueTag = issueIdx + 1'b1;

    // Head retires in the cycle it is done
    assign commitEn   = entValid[headPtr] && entDone[headPtr] && !flush;
    assign commitRd   = entRd[headPtr];
    assign commitTag  = headPtr + 1'b1;
    assign commitData = entResult[headPtr];
    assign commitPc   = entPc[headPtr];

    assign resIdx = resultTag - tagT'(1);

    // ****************************************
    // Entry state
    // ****************************************

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            headPtr   <= '0;
            tailPtr   <= '0;
            count     <= '0;
            entValid  <= '0;
            entIssued <= '0;
            entDone   <= '0;
            entARdy   <= '0;
            entBRdy   <= '0;
        end else begin
            if (resultEn) begin
                for (int i = 0; i < `ROB_DEPTH; i++) begin
                    if (entValid[i] && !entARdy[i] && entATag[i] == resultTag) begin
                        entARdy[i] <= 1'b1;
                        entAVal[i] <= resultData;
                    end
                    if (entValid[i] && !entBRdy[i] && entBTag[i] == resultTag) begin
                        entBRdy[i] <= 1'b1;
                        entBVal[i] <= resultData;
                    end
                end
                if (resultTag != '0 && entValid[resIdx]) begin
                    entDone[resIdx]   <= 1'b1;
                    entResult[resIdx] <= resultData;
                end
            end

            if (issueEn) begin
                entIssued[issueIdx] <= 1'b1;
            end

            if (commitEn) begin
                entValid[headPtr] <= 1'b0;
                headPtr           <= nextPtr(headPtr);
            end

            // The tail slot is free, so none of the updates above touch it
            if (accept) begin
                entValid[tailPtr]  <= 1'b1;
                entIssued[tailPtr] <= 1'b0;
                entDone[tailPtr]   <= 1'b0;
                entARdy[tailPtr]   <= newARdy;
                entBRdy[tailPtr]   <= newBRdy;
                entAVal[tailPtr]   <= newAVal;
                entBVal[tailPtr]   <= newBVal;
                entATag[tailPtr]   <= newATag;
                entBTag[tailPtr]   <= newBTag;
                entOp[tailPtr]     <= inOp;
                entRd[tailPtr]     <= inRd;
                entPc[tailPtr]     <= inPc;
                tailPtr            <= nextPtr(tailPtr);
            end

            case ({accept, commitEn})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: verilog/regFile.sv
`timescale 1ns/1ps
`include "rename_params.svh"

module regFile
    import renamePkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    flush,

    // Dispatch reads
    input  regNameT rs1,
    input  regNameT rs2,
    output dataT    rs1Data,
    output dataT    rs2Data,
    output tagT     rs1Tag,
    output tagT     rs2Tag,

    // Rename of the destination at dispatch
    input  logic    renameEn,
    input  regNameT renameRd,
    input  tagT     renameTag,

    // In-order commit
    input  logic    commitEn,
    input  regNameT commitRd,
    input  tagT     commitTag,
    input  dataT    commitData
);

    dataT regData [`REG_NUM];
    tagT  regTag  [`REG_NUM];

    // ****************************************
    // Combinational source reads
    // ****************************************

    // x0 is hardwired to zero and never pending
    assign rs1Data = (rs1 == '0) ? '0 : regData[rs1];
    assign rs1Tag  = (rs1 == '0) ? '0 : regTag[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : regData[rs2];
    assign rs2Tag  = (rs2 == '0) ? '0 : regTag[rs2];

    // ****************************************
    // Commit, rename and flush
    // ****************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regData[i] <= '0;
                regTag[i]  <= '0;
            end
        end else begin
            if (commitEn && commitRd != '0) begin
                regData[commitRd] <= commitData;
                // A younger writer may already own this register
                if (regTag[commitRd] == commitTag) begin
                    regTag[commitRd] <= '0;
                end
            end

            // Comes after the commit so a same-cycle rename keeps its tag
            if (renameEn && renameRd != '0) begin
                regTag[renameRd] <= renameTag;
            end

            // Values survive a flush and only the pending tags are cleared
            if (flush) begin
                for (int i = 0; i < `REG_NUM; i++) begin
                    regTag[i] <= '0;
                end
            end
        end
    end

endmodule

// File: verilog/renamePkg.sv
`include "rename_params.svh"

package renamePkg;

    // ****************************************
    // Vector types
    // ****************************************

    // Register values, immediates and pc
    typedef logic [`DATA_W-1:0] dataT;

    typedef logic [`NAME_W-1:0] regNameT;

    // Zero tag marks a register with no write in flight
    typedef logic [`TAG_W-1:0] tagT;

    typedef logic [`OP_W-1:0] opT;

    // ****************************************
    // Operation codes
    // ****************************************

    localparam opT OP_ADD  = opT'(0);
    localparam opT OP_SUB  = opT'(1);
    localparam opT OP_AND  = opT'(2);
    localparam opT OP_OR   = opT'(3);
    localparam opT OP_XOR  = opT'(4);
    localparam opT OP_SLT  = opT'(5);

    // Immediate forms take their second operand from the immediate field.
    // LUI expects the immediate already shifted into the upper bits
    localparam opT OP_ADDI = opT'(6);
    localparam opT OP_LUI  = opT'(7);

endpackage

// File: include/rename_params.svh
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// Architectural register file
`define REG_NUM   32
`define DATA_W    32
`define NAME_W    5

// Rename tags run 1 to ROB_DEPTH and tag 0 means no write pending
`define TAG_W     3
`define ROB_DEPTH 7

`define OP_W      4

`endif
